//--- hdl/flash_wr_pkg.sv
`default_nettype none

package flash_wr_pkg;

   ////////////////////////////////////////////////////////////
   // Widths
   ////////////////////////////////////////////////////////////
   localparam int OPERAND_W = 48;          // Operand from the instruction handler
   localparam int DQ_W      = 8;           // Data pins on the flash bus
   localparam int BITCNT_W  = 6;           // Valid bit count or dummy cycle count
   localparam int CS_CNT_W  = 2;           // Chip select setup and hold counts

   // Slice taken from the top of the shift register each cycle
   // Wide enough for 8 pins on both clock edges
   localparam int SLICE_W   = 2 * DQ_W;

   ////////////////////////////////////////////////////////////
   // Shift step constants
   ////////////////////////////////////////////////////////////
   localparam int STEP_W    = 5;           // Holds a step of up to 16 bits
   localparam int STEP_LG_W = 3;           // Log2 of the step, pin code plus DDR

   ////////////////////////////////////////////////////////////
   // Encodings
   ////////////////////////////////////////////////////////////

   // Bus width, pin count is 1 << code
   typedef enum logic [1:0]
   {
      PINS_1 = 2'd0,
      PINS_2 = 2'd1,
      PINS_4 = 2'd2,
      PINS_8 = 2'd3
   } pin_mode_e;

   // Chip select sequencing
   typedef enum logic [1:0]
   {
      CS_IDLE   = 2'd0,                    // chip_sel high
      CS_SETUP  = 2'd1,                    // chip_sel low, counting css
      CS_ACTIVE = 2'd2,                    // Operands shifting out
      CS_HOLD   = 2'd3                     // Counting csh before release
   } cs_state_e;

endpackage

`default_nettype wire

//--- hdl/cs_timing.sv
`timescale 1ns/1ps
`default_nettype none

module cs_timing
(
   input  logic                              mem_clk,
   input  logic                              reset_n,
   input  logic                              write_enable,  // Level from instruction handler
   input  logic [flash_wr_pkg::CS_CNT_W-1:0] css,           // Setup count
   input  logic [flash_wr_pkg::CS_CNT_W-1:0] csh,           // Hold count
   input  logic                              xfer_done,     // Last operand sent and stop seen
   input  logic                              slice_valid,   // Shifter issued a slice
   output logic                              chip_sel,
   output logic                              shift_go,
   output logic                              sclk_en
);

   flash_wr_pkg::cs_state_e           state;
   logic [flash_wr_pkg::CS_CNT_W-1:0] cnt;             // Shared setup and hold counter
   logic                              write_enable_d;
   logic                              we_rise;

   // New instruction starts on a rising edge of the request level
   assign we_rise  = write_enable & ~write_enable_d;

   // Shifter may run only inside the active window
   assign shift_go = (state == flash_wr_pkg::CS_ACTIVE);

   ////////////////////////////////////////////////////////////
   // Chip select FSM
   ////////////////////////////////////////////////////////////
   always_ff @(posedge mem_clk or negedge reset_n)
   begin
      if (!reset_n)
      begin
         state          <= flash_wr_pkg::CS_IDLE;
         cnt            <= '0;
         chip_sel       <= 1'b1;                       // Deselected out of reset
         write_enable_d <= 1'b0;
         sclk_en        <= 1'b0;
      end
      else
      begin
         write_enable_d <= write_enable;
         // Delay matches the lane output register
         sclk_en        <= slice_valid;
         case (state)
            flash_wr_pkg::CS_IDLE:
            begin
               if (we_rise)
               begin
                  chip_sel <= 1'b0;                    // Select the device
                  if (css == '0)
                     state <= flash_wr_pkg::CS_ACTIVE; // No setup wait
                  else
                  begin
                     state <= flash_wr_pkg::CS_SETUP;
                     cnt   <= css - 1'b1;
                  end
               end
            end
            flash_wr_pkg::CS_SETUP:
            begin
               if (cnt == '0)
                  state <= flash_wr_pkg::CS_ACTIVE;
               else
                  cnt <= cnt - 1'b1;
            end
            flash_wr_pkg::CS_ACTIVE:
            begin
               // Stays here through back-pressure gaps
               if (xfer_done)
               begin
                  state <= flash_wr_pkg::CS_HOLD;
                  cnt   <= csh;
               end
            end
            flash_wr_pkg::CS_HOLD:
            begin
               if (cnt == '0)
               begin
                  state    <= flash_wr_pkg::CS_IDLE;
                  chip_sel <= 1'b1;                    // Release after hold
               end
               else
                  cnt <= cnt - 1'b1;
            end
            default:
               state <= flash_wr_pkg::CS_IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- hdl/operand_shifter.sv
`timescale 1ns/1ps
`default_nettype none

module operand_shifter
(
   input  logic                                mem_clk,
   input  logic                                reset_n,
   input  logic                                shift_go,            // Active window from cs_timing
   input  logic                                write_enable,
   input  logic                                stop_instrn,
   input  flash_wr_pkg::pin_mode_e             no_of_pins,
   input  logic                                ddr_en,
   input  logic [flash_wr_pkg::OPERAND_W-1:0]  operand,             // MSB goes out first
   input  logic [flash_wr_pkg::BITCNT_W:0]     valid_operand_bits,  // [6] dummy, [5:0] count
   output logic                                slice_valid,
   output logic                                slice_dummy,
   output logic [flash_wr_pkg::SLICE_W-1:0]    slice_word,
   output logic                                data_ack,
   output logic                                dummy_end,
   output logic                                xfer_done
);

   logic [flash_wr_pkg::OPERAND_W-1:0] shift_reg;
   logic [flash_wr_pkg::STEP_W-1:0]    step_q;     // Step of the operand in flight
   logic [flash_wr_pkg::BITCNT_W-1:0]  cycle_cnt;  // Slices left after this one
   logic [flash_wr_pkg::STEP_LG_W-1:0] step_log2;
   logic [flash_wr_pkg::STEP_W-1:0]    step;
   logic [flash_wr_pkg::BITCNT_W-1:0]  bit_cnt;
   logic [flash_wr_pkg::BITCNT_W:0]    bits_rnd;
   logic [flash_wr_pkg::BITCNT_W:0]    cyc_raw;
   logic [flash_wr_pkg::BITCNT_W-1:0]  op_cycles;
   logic [flash_wr_pkg::BITCNT_W-1:0]  cnt_init;
   logic                               is_dummy;
   logic                               load;

   ////////////////////////////////////////////////////////////
   // Cycle count for the presented operand
   ////////////////////////////////////////////////////////////
   assign is_dummy  = valid_operand_bits[flash_wr_pkg::BITCNT_W];
   assign bit_cnt   = valid_operand_bits[flash_wr_pkg::BITCNT_W-1:0];

   // Bits per cycle is pins times two for DDR, always a power of two
   assign step_log2 = {1'b0, no_of_pins} + {2'b00, ddr_en};
   assign step      = 5'd1 << step_log2;

   // Round up before dividing by the step
   assign bits_rnd  = {1'b0, bit_cnt} + {2'b00, step} - 7'd1;
   assign cyc_raw   = bits_rnd >> step_log2;

   // Dummy phases count cycles directly
   assign op_cycles = is_dummy ? bit_cnt : cyc_raw[flash_wr_pkg::BITCNT_W-1:0];
   assign cnt_init  = (op_cycles == '0) ? '0 : op_cycles - 1'b1;   // Minimum of one cycle

   ////////////////////////////////////////////////////////////
   // Handshakes
   ////////////////////////////////////////////////////////////

   // Take a new operand only between operands and only while not stopping
   assign load       = shift_go & write_enable & ~slice_valid & ~stop_instrn;

   assign data_ack   = slice_valid & (cycle_cnt == '0);   // Last slice of the operand
   assign dummy_end  = data_ack & slice_dummy;
   // Stop is seen after the last slice has gone out
   assign xfer_done  = shift_go & ~slice_valid & stop_instrn;

   assign slice_word = shift_reg[flash_wr_pkg::OPERAND_W-1 -: flash_wr_pkg::SLICE_W];

   ////////////////////////////////////////////////////////////
   // Control registers
   ////////////////////////////////////////////////////////////
   always_ff @(posedge mem_clk or negedge reset_n)
   begin
      if (!reset_n)
      begin
         slice_valid <= 1'b0;
         slice_dummy <= 1'b0;
         cycle_cnt   <= '0;
      end
      else if (load)
      begin
         slice_valid <= 1'b1;
         slice_dummy <= is_dummy;
         cycle_cnt   <= cnt_init;
      end
      else if (slice_valid)
      begin
         if (cycle_cnt == '0)
            slice_valid <= 1'b0;             // Wait for next operand or stop
         else
            cycle_cnt <= cycle_cnt - 1'b1;
      end
   end

   // Data path
   always_ff @(posedge mem_clk)
   begin
      if (load)
      begin
         shift_reg <= operand;
         step_q    <= step;
      end
      else if (slice_valid)
         shift_reg <= shift_reg << step_q;   // Next slice moves to the top
   end

endmodule

`default_nettype wire

//--- hdl/dq_lane.sv
`timescale 1ns/1ps
`default_nettype none

module dq_lane
#(
   parameter int LANE = 0                             // Pin index, below DQ_W
)
(
   input  logic                             mem_clk,
   input  logic                             reset_n,
   input  flash_wr_pkg::pin_mode_e          no_of_pins,
   input  logic                             ddr_en,
   input  logic                             slice_valid,
   input  logic                             slice_dummy,
   input  logic [flash_wr_pkg::SLICE_W-1:0] slice_word,
   input  logic                             hiz,         // Float this pin in dummy phases
   output logic                             dq_rise,
   output logic                             dq_fall,
   output logic                             oe
);

   logic [3:0]                       pins;
   logic                             lane_active;
   logic [flash_wr_pkg::SLICE_W-1:0] fall_word;

   assign pins        = 4'd1 << no_of_pins;
   assign lane_active = (4'(LANE) < pins);
   // Falling edge data sits one pin group below the rising edge data
   assign fall_word   = slice_word << pins;

   ////////////////////////////////////////////////////////////
   // Output registers
   ////////////////////////////////////////////////////////////
   always_ff @(posedge mem_clk or negedge reset_n)
   begin
      if (!reset_n)
      begin
         dq_rise <= 1'b0;
         dq_fall <= 1'b0;
         oe      <= 1'b0;
      end
      else if (slice_valid && slice_dummy)
      begin
         dq_rise <= 1'b0;                             // No data in dummy
         dq_fall <= 1'b0;
         oe      <= ~hiz;
      end
      else if (slice_valid && lane_active)
      begin
         dq_rise <= slice_word[flash_wr_pkg::SLICE_W-1-LANE];
         // SDR repeats the bit on both edges
         dq_fall <= ddr_en ? fall_word[flash_wr_pkg::SLICE_W-1-LANE]
                           : slice_word[flash_wr_pkg::SLICE_W-1-LANE];
         oe      <= 1'b1;
      end
      else
         oe      <= 1'b0;                             // Data held, pin released
   end

endmodule

`default_nettype wire

//--- hdl/flash_write_engine.sv
`timescale 1ns/1ps
`default_nettype none

module flash_write_engine
(
   input  logic                                mem_clk,
   input  logic                                reset_n,
   // Instruction handler
   input  logic                                write_enable,        // Request level
   input  flash_wr_pkg::pin_mode_e             no_of_pins,
   input  logic                                ddr_en,
   input  logic [flash_wr_pkg::OPERAND_W-1:0]  operand,
   input  logic [flash_wr_pkg::BITCNT_W:0]     valid_operand_bits,
   input  logic                                stop_instrn,
   // CSR
   input  logic [flash_wr_pkg::CS_CNT_W-1:0]   css,
   input  logic [flash_wr_pkg::CS_CNT_W-1:0]   csh,
   input  logic [flash_wr_pkg::DQ_W-1:0]       dummy_cyc_hiz,
   // Back to the handler
   output logic                                data_ack,            // Next operand please
   output logic                                dummy_end,
   // Flash pins
   output logic                                sclk_en,
   output logic [flash_wr_pkg::SLICE_W-1:0]    dq_out,              // [7:0] rise, [15:8] fall
   output logic [flash_wr_pkg::SLICE_W-1:0]    dq_oe,
   output logic                                chip_sel
);

   logic                             shift_go;
   logic                             xfer_done;
   logic                             slice_valid;
   logic                             slice_dummy;
   logic [flash_wr_pkg::SLICE_W-1:0] slice_word;
   logic [flash_wr_pkg::DQ_W-1:0]    lane_rise;
   logic [flash_wr_pkg::DQ_W-1:0]    lane_fall;
   logic [flash_wr_pkg::DQ_W-1:0]    lane_oe;

   ////////////////////////////////////////////////////////////
   // Chip select and clock enable
   ////////////////////////////////////////////////////////////
   cs_timing cs_timing_i
   (
      .mem_clk      (mem_clk),
      .reset_n      (reset_n),
      .write_enable (write_enable),
      .css          (css),
      .csh          (csh),
      .xfer_done    (xfer_done),
      .slice_valid  (slice_valid),
      .chip_sel     (chip_sel),
      .shift_go     (shift_go),
      .sclk_en      (sclk_en)
   );

   // Operand load and shift
   operand_shifter operand_shifter_i
   (
      .mem_clk            (mem_clk),
      .reset_n            (reset_n),
      .shift_go           (shift_go),
      .write_enable       (write_enable),
      .stop_instrn        (stop_instrn),
      .no_of_pins         (no_of_pins),
      .ddr_en             (ddr_en),
      .operand            (operand),
      .valid_operand_bits (valid_operand_bits),
      .slice_valid        (slice_valid),
      .slice_dummy        (slice_dummy),
      .slice_word         (slice_word),
      .data_ack           (data_ack),
      .dummy_end          (dummy_end),
      .xfer_done          (xfer_done)
   );

   ////////////////////////////////////////////////////////////
   // One lane per data pin
   ////////////////////////////////////////////////////////////
   for (genvar i = 0; i < flash_wr_pkg::DQ_W; i++)
   begin : g_lane
      dq_lane #(.LANE(i)) dq_lane_i
      (
         .mem_clk     (mem_clk),
         .reset_n     (reset_n),
         .no_of_pins  (no_of_pins),
         .ddr_en      (ddr_en),
         .slice_valid (slice_valid),
         .slice_dummy (slice_dummy),
         .slice_word  (slice_word),
         .hiz         (dummy_cyc_hiz[i]),
         .dq_rise     (lane_rise[i]),
         .dq_fall     (lane_fall[i]),
         .oe          (lane_oe[i])
      );
   end

   assign dq_out = {lane_fall, lane_rise};
   assign dq_oe  = {lane_oe, lane_oe};                // Same enable on both edges

endmodule

`default_nettype wire

//--- testbench/tb_flash_write_engine.sv
`timescale 1ns/1ps
`default_nettype none

module tb_flash_write_engine;

   localparam int CLK_HALF   = 5;                    // 10 ns period
   localparam int RESET_CYC  = 16;
   localparam int FIELDS     = 9;                    // Numbers per pattern line
   localparam int MAX_OPS    = 64;
   localparam int OP_MARGIN  = 10;                   // Timeout slack per operand
   localparam int RUN_MARGIN = 100;

   logic                                     mem_clk;
   logic                                     reset_n;
   logic                                     write_enable;
   flash_wr_pkg::pin_mode_e                  no_of_pins;
   logic                                     ddr_en;
   logic [flash_wr_pkg::OPERAND_W-1:0]       operand;
   logic [flash_wr_pkg::BITCNT_W:0]          valid_operand_bits;
   logic                                     stop_instrn;
   logic [flash_wr_pkg::CS_CNT_W-1:0]        css;
   logic [flash_wr_pkg::CS_CNT_W-1:0]        csh;
   logic [flash_wr_pkg::DQ_W-1:0]            dummy_cyc_hiz;
   logic                                     data_ack;
   logic                                     dummy_end;
   logic                                     sclk_en;
   logic [flash_wr_pkg::SLICE_W-1:0]         dq_out;  // [7:0] rise, [15:8] fall
   logic [flash_wr_pkg::SLICE_W-1:0]         dq_oe;
   logic                                     chip_sel;

   logic [47:0] pat_mem [0:FIELDS*MAX_OPS-1];        // FIELDS words per operand
   int          num_ops;
   int          cycle_count;
   int          cycle_limit;
   integer      seed;
   int          op;
   int          instr;
   int          check_count;
   int          error_count;
   int          test_count;
   int          op_err_start;                        // Errors before current test
   // Operand on the bus now
   int          cur_pins;
   logic        cur_ddr;
   logic        cur_dummy;
   logic [7:0]  cur_hiz;
   logic [47:0] cur_operand;
   int          cur_bits;
   int          cur_csh;
   // Bus monitor results
   logic [47:0] rebuilt;                             // Bits seen on dq, MSB first
   int          bit_pos;
   int          slice_count;
   int          ack_count;
   int          dend_count;
   logic        instr_active;                        // chip_sel must be low
   logic        quiet_bus;                           // No slice allowed

   flash_write_engine dut_i
   (
      .mem_clk            (mem_clk),
      .reset_n            (reset_n),
      .write_enable       (write_enable),
      .no_of_pins         (no_of_pins),
      .ddr_en             (ddr_en),
      .operand            (operand),
      .valid_operand_bits (valid_operand_bits),
      .stop_instrn        (stop_instrn),
      .css                (css),
      .csh                (csh),
      .dummy_cyc_hiz      (dummy_cyc_hiz),
      .data_ack           (data_ack),
      .dummy_end          (dummy_end),
      .sclk_en            (sclk_en),
      .dq_out             (dq_out),
      .dq_oe              (dq_oe),
      .chip_sel           (chip_sel)
   );

   initial
      mem_clk = 1'b0;
   always #CLK_HALF mem_clk = ~mem_clk;

   // Run limit, set from the pattern lengths
   always @(posedge mem_clk)
   begin
      cycle_count = cycle_count + 1;
      if (cycle_count > cycle_limit)
      begin
         $display("Run timed out after %0d cycles, DUT stopped responding", cycle_count);
         $display("CHECKS FAILED");
         $finish;
      end
   end

   ////////////////////////////////////////////////////////////
   // Reference model and checks
   ////////////////////////////////////////////////////////////

   // Slices per operand from mode, DDR and bit count
   function automatic int expected_cycles(input int mode, input logic ddr,
                                          input logic dummy, input int count);
      int step;
      int cycles;
      step   = (1 << mode) * (ddr ? 2 : 1);
      cycles = (count + step - 1) / step;          // Round up
      if (dummy)
         cycles = count;                            // Dummy counts cycles
      else if (cycles == 0)
         cycles = 1;
      return cycles;
   endfunction

   task automatic check_value(input string name, input logic [47:0] expected,
                              input logic [47:0] actual);
      check_count++;
      if (actual !== expected)
      begin
         error_count++;
         $display("** Error at time %0t: %s expected %h, got %h", $time, name, expected, actual);
      end
   endtask

   // One clock, then sample the bus at the falling edge
   task automatic sample_cycle();
      logic [7:0] pmask;
      logic [7:0] exp_byte;
      int         j;
      @(negedge mem_clk);
      pmask = 8'((1 << cur_pins) - 1);              // Active lanes
      if (data_ack)
         ack_count++;
      if (dummy_end)
         dend_count++;
      if (instr_active)
         check_value("chip_sel", 0, chip_sel);
      if (quiet_bus)
         check_value("sclk_en", 0, sclk_en);
      else if (sclk_en)
      begin
         slice_count++;
         if (cur_dummy)
         begin
            check_value("dq_oe", {~cur_hiz, ~cur_hiz}, dq_oe);
            check_value("dq_out", 0, dq_out);       // Nothing driven in dummy
         end
         else
         begin
            check_value("dq_oe", {pmask, pmask}, dq_oe);
            if (!cur_ddr)
            begin
               // Operand bits due on this slice, zero once shifted past the end
               exp_byte = '0;
               for (j = 0; j < cur_pins; j++)
                  if (bit_pos - j >= 0)
                     exp_byte[j] = cur_operand[bit_pos - j];
               check_value("dq_out fall byte", exp_byte, dq_out[15:8] & pmask);
            end
            for (j = 0; j < cur_pins; j++)
               if (bit_pos - j >= 0)
                  rebuilt[bit_pos - j] = dq_out[j];
            bit_pos = bit_pos - cur_pins;
            if (cur_ddr)
            begin
               for (j = 0; j < cur_pins; j++)
                  if (bit_pos - j >= 0)
                     rebuilt[bit_pos - j] = dq_out[8 + j];   // Falling edge follows
               bit_pos = bit_pos - cur_pins;
            end
         end
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Handler side
   ////////////////////////////////////////////////////////////
   task automatic present_operand(input int idx);
      int b;
      b                  = idx * FIELDS;
      no_of_pins         = flash_wr_pkg::pin_mode_e'(pat_mem[b][1:0]);
      ddr_en             = pat_mem[b+1][0];
      valid_operand_bits = {pat_mem[b+2][0], pat_mem[b+3][5:0]};
      operand            = pat_mem[b+4];
      dummy_cyc_hiz      = pat_mem[b+5][7:0];
      css                = pat_mem[b+6][1:0];
      csh                = pat_mem[b+7][1:0];
      write_enable       = 1'b1;
      cur_pins           = 1 << pat_mem[b][1:0];
      cur_ddr            = pat_mem[b+1][0];
      cur_dummy          = pat_mem[b+2][0];
      cur_bits           = pat_mem[b+3][5:0];
      cur_operand        = pat_mem[b+4];
      cur_hiz            = pat_mem[b+5][7:0];
      cur_csh            = pat_mem[b+7][1:0];
      rebuilt            = '0;
      bit_pos            = 47;
      slice_count        = 0;
      ack_count          = 0;
      dend_count         = 0;
      op_err_start       = error_count;
   endtask

   task automatic finish_operand(input int idx);
      int          exp_cyc;
      logic [47:0] mask;
      exp_cyc = expected_cycles(cur_pins == 1 ? 0 : cur_pins == 2 ? 1 : cur_pins == 4 ? 2 : 3,
                                cur_ddr, cur_dummy, cur_bits);
      mask    = (cur_bits == 0) ? '0 : {48{1'b1}} << (48 - cur_bits);   // Top bits only
      check_value("sclk_en cycles", exp_cyc, slice_count);
      check_value("data_ack pulses", 1, ack_count);
      check_value("dummy_end pulses", cur_dummy, dend_count);
      if (!cur_dummy)
         check_value("rebuilt data", cur_operand & mask, rebuilt & mask);
      test_count++;
      $display("op %0d: %0d pin(s) %s %s, %0d cycles: %s", idx, cur_pins,
               cur_ddr ? "DDR" : "SDR", cur_dummy ? "dummy" : "data", exp_cyc,
               (error_count == op_err_start) ? "pass" : "fail");
   endtask

   // Random pause between operands
   task automatic insert_gap();
      int gap;
      gap = $random(seed) & 3;
      if (gap > 0)
      begin
         write_enable = 1'b0;                      // Handler not ready
         quiet_bus    = 1'b1;
         repeat (gap) sample_cycle();
         quiet_bus    = 1'b0;
      end
   endtask

   task automatic end_instruction(input int idx);
      int wait_cyc;
      int err_before;
      err_before   = error_count;
      write_enable = 1'b0;
      stop_instrn  = 1'b1;
      instr_active = 1'b0;
      quiet_bus    = 1'b1;                          // No slice after stop
      wait_cyc     = 0;
      while (chip_sel !== 1'b1 && wait_cyc < cur_csh + 3)
      begin
         sample_cycle();
         wait_cyc++;
      end
      check_value("chip_sel", 1, chip_sel);
      stop_instrn = 1'b0;
      sample_cycle();                               // Idle, still deselected
      check_value("chip_sel", 1, chip_sel);
      quiet_bus   = 1'b0;
      test_count++;
      $display("instruction %0d: chip select released after %0d cycles: %s", idx, wait_cyc,
               (error_count == err_before) ? "pass" : "fail");
   endtask

   ////////////////////////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////////////////////////
   initial
   begin
      seed               = 32'h727cdee5;
      reset_n            = 1'b0;
      write_enable       = 1'b0;
      no_of_pins         = flash_wr_pkg::PINS_1;
      ddr_en             = 1'b0;
      operand            = '0;
      valid_operand_bits = '0;
      stop_instrn        = 1'b0;
      css                = '0;
      csh                = '0;
      dummy_cyc_hiz      = '0;
      cycle_count        = 0;
      check_count        = 0;
      error_count        = 0;
      test_count         = 0;
      instr              = 0;
      instr_active       = 1'b0;
      quiet_bus          = 1'b1;
      cur_pins           = 1;
      cur_ddr            = 1'b0;
      cur_dummy          = 1'b0;
      cur_hiz            = '0;
      cur_csh            = 0;

      $readmemh("testbench/wr_patterns.txt", pat_mem);
      num_ops = 0;
      while (num_ops < MAX_OPS && !$isunknown(pat_mem[num_ops*FIELDS]))
         num_ops++;
      cycle_limit = RUN_MARGIN;
      for (op = 0; op < num_ops; op++)
         cycle_limit += expected_cycles(pat_mem[op*FIELDS][1:0], pat_mem[op*FIELDS+1][0],
                                        pat_mem[op*FIELDS+2][0], pat_mem[op*FIELDS+3][5:0])
                        + pat_mem[op*FIELDS+6][1:0] + pat_mem[op*FIELDS+7][1:0] + OP_MARGIN;
      if (num_ops == 0)
      begin
         error_count++;
         $display("No operands could be read from the pattern file");
      end

      // Reset values, checked while reset is still low
      repeat (RESET_CYC) @(negedge mem_clk);
      op_err_start = error_count;
      check_value("chip_sel", 1, chip_sel);
      check_value("sclk_en", 0, sclk_en);
      check_value("data_ack", 0, data_ack);
      check_value("dummy_end", 0, dummy_end);
      check_value("dq_out", 0, dq_out);
      check_value("dq_oe", 0, dq_oe);
      test_count++;
      $display("reset values: %s", (error_count == op_err_start) ? "pass" : "fail");
      reset_n = 1'b1;
      sample_cycle();
      quiet_bus = 1'b0;

      for (op = 0; op < num_ops; op++)
      begin
         present_operand(op);
         instr_active = 1'b1;
         while (ack_count == 0)
            sample_cycle();
         sample_cycle();                            // Last slice reaches dq
         finish_operand(op);
         if (pat_mem[op*FIELDS+8][0])
         begin
            end_instruction(instr);
            instr++;
         end
         else
            insert_gap();
      end

      $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
      if (error_count == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

//--- src.f
hdl/flash_wr_pkg.sv
hdl/cs_timing.sv
hdl/operand_shifter.sv
hdl/dq_lane.sv
hdl/flash_write_engine.sv
testbench/tb_flash_write_engine.sv

//--- testbench/wr_patterns.txt
// mode(0..3 = 1,2,4,8 pins) ddr dummy count operand hiz css csh last
// count is data bits, or cycles for a dummy phase; last closes the instruction
0 0 0 08 020000000000 00 1 1 0
0 0 0 18 A5C3E1000000 00 1 1 0
0 0 0 30 123456789ABC 00 1 1 1
1 0 0 08 3B0000000000 00 0 2 0
1 1 0 18 00FF10000000 00 0 2 0
1 0 1 04 000000000000 0F 0 2 0
1 1 0 20 DEADBEEF0000 00 0 2 1
0 0 0 08 EB0000000000 00 2 0 0
2 1 0 18 C0FFEE000000 00 2 0 0
2 0 1 06 000000000000 F0 2 0 0
2 0 0 2D 5A5A5A5A5A5A 00 2 0 0
2 1 0 01 800000000000 00 2 0 1
3 0 0 10 A55A00000000 00 3 3 0
3 1 0 30 0123456789AB 00 3 3 0
3 1 1 02 000000000000 AA 3 3 0
3 0 0 00 FFFFFFFFFFFF 00 3 3 1
0 0 1 01 000000000000 00 1 0 0
3 0 0 29 FEDCBA987654 00 1 0 0
1 0 0 07 7E0000000000 00 1 0 1
